//--- sources.f
+incdir+verilog
verilog/ofs_sim_pkg.sv
verilog/sim_reset_gen.sv
verilog/host_chan_emul.sv
verilog/local_mem_model.sv
verilog/afu_mem_sum.sv
verilog/sim_platform_top.sv
verification/tb_clock_gen.sv
verification/tb_sim_platform.sv

//--- run_sim.sh
#!/bin/sh
# Builds the platform testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_sim_platform \
    -f sources.f \
    -o tb_sim_platform

./obj_dir/tb_sim_platform | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation finished cleanly"

//--- verification/tb_sim_platform.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

module tb_sim_platform;

    import ofs_sim_pkg::*;

    localparam int ADDR_W = `OFS_HOST_ADDR_WIDTH;
    localparam int MEM_AW = `OFS_MEM_ADDR_WIDTH;
    localparam int MEM_WORDS = 2 ** MEM_AW;
    localparam int WIN_WORDS = 16;
    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 100;
    localparam int ISSUE_LIMIT = 32;
    localparam int STALL_LIMIT = 16;
    // Both host channel FIFOs full plus the one response the AFU holds back
    localparam int BACKLOG_READS = 2 * `OFS_HOST_FIFO_DEPTH + 1;
    localparam logic [ADDR_W-1:0] CSR_SCRATCH = ADDR_W'(`OFS_CSR_SCRATCH);
    localparam logic [ADDR_W-1:0] CSR_COMMAND = ADDR_W'(`OFS_CSR_COMMAND);
    localparam logic [ADDR_W-1:0] CSR_SUM = ADDR_W'(`OFS_CSR_SUM);
    localparam logic [ADDR_W-1:0] CSR_STATUS = ADDR_W'(`OFS_CSR_STATUS);
    localparam logic [ADDR_W-1:0] WIN_BASE = {1'b1, {(ADDR_W-1){1'b0}}};
    // Status word layout is busy in bit 0, done in bit 1 and cmd_error in bit 2
    localparam logic [31:0] STATUS_DONE = 32'h0000_0002;
    localparam logic [31:0] STATUS_ERR_DONE = 32'h0000_0006;

    logic      pClk;
    logic      arst_n;
    logic      soft_reset_req;
    host_req_t host_req;
    logic      host_req_valid;
    logic      host_req_ready;
    host_rsp_t host_rsp;
    logic      host_rsp_valid;
    logic      host_rsp_ready;

    // Reference copy of local memory and the scattered window addresses
    logic [31:0]       mem_model [MEM_WORDS];
    logic [MEM_AW-1:0] win_addrs [WIN_WORDS];
    logic [31:0]       rng_state;
    int                checks;
    int                errors;

    tb_clock_gen #(.HALF_PERIOD(2), .RESET_CYCLES(3)) clock_gen
    (
        .pClk(pClk),
        .arst_n(arst_n)
    );

    sim_platform_top DUT
    (
        .pClk(pClk),
        .arst_n(arst_n),
        .soft_reset_req(soft_reset_req),
        .host_req(host_req),
        .host_req_valid(host_req_valid),
        .host_req_ready(host_req_ready),
        .host_rsp(host_rsp),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp_ready(host_rsp_ready)
    );

    // ==========================================================================
    // Helper tasks that are entered and left on a falling edge
    // ==========================================================================

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // The top address bit steers a request into the memory window
    function automatic logic [ADDR_W-1:0] window_addr(input logic [MEM_AW-1:0] addr);
        return WIN_BASE | ADDR_W'(addr);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual == expected)
        else
        begin
            $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    // A stuck handshake ends the run at once
    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_link_up();
        int cycles;
        cycles = 0;
        while (!host_req_ready && cycles < WAIT_LIMIT)
        begin
            @(negedge pClk);
            cycles++;
        end
        if (!host_req_ready)
            abort_run("Host channel never came out of reset");
    endtask

    // Ready depends only on channel state, so the value seen here holds at the next edge
    task automatic send_req(input logic is_write, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] data);
        int cycles;
        cycles = 0;
        host_req.is_write = is_write;
        host_req.addr = addr;
        host_req.data.raw = data;
        host_req_valid = 1'b1;
        while (!host_req_ready && cycles < WAIT_LIMIT)
        begin
            @(negedge pClk);
            cycles++;
        end
        if (!host_req_ready)
            abort_run("Host request was never accepted");
        @(negedge pClk);
        host_req_valid = 1'b0;
    endtask

    task automatic recv_rsp(output logic [31:0] data);
        int cycles;
        cycles = 0;
        while (!host_rsp_valid && cycles < WAIT_LIMIT)
        begin
            @(negedge pClk);
            cycles++;
        end
        if (!host_rsp_valid)
            abort_run("No host response arrived for a read");
        data = host_rsp.data;
        host_rsp_ready = 1'b1;
        @(negedge pClk);
        host_rsp_ready = 1'b0;
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        send_req(1'b1, addr, data);
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        send_req(1'b0, addr, 32'h0);
        recv_rsp(data);
    endtask

    task automatic host_command(input logic [MEM_AW-1:0] base, input int count);
        sum_cmd_t cmd;
        cmd.base = 16'(base);
        cmd.count = 16'(count);
        host_write(CSR_COMMAND, cmd);
    endtask

    task automatic wait_sum_done(output logic [31:0] status);
        int polls;
        polls = 0;
        host_read(CSR_STATUS, status);
        while (!status[1] && polls < POLL_LIMIT)
        begin
            host_read(CSR_STATUS, status);
            polls++;
        end
        if (!status[1])
            abort_run("Summing engine never reported done");
    endtask

    task automatic fill_range(input logic [MEM_AW-1:0] base, input int count);
        logic [MEM_AW-1:0] addr;
        logic [31:0]       value;
        for (int i = 0; i < count; i++)
        begin
            // Address arithmetic wraps at the end of the array
            addr = base + MEM_AW'(i);
            value = next_random();
            mem_model[addr] = value;
            host_write(window_addr(addr), value);
        end
    endtask

    task automatic run_sum(input string name, input logic [MEM_AW-1:0] base, input int count);
        logic [MEM_AW-1:0] addr;
        logic [31:0]       expected;
        logic [31:0]       data;
        expected = 32'h0;
        for (int i = 0; i < count; i++)
        begin
            addr = base + MEM_AW'(i);
            expected = expected + mem_model[addr];
        end
        host_command(base, count);
        wait_sum_done(data);
        check_value({name, " status"}, STATUS_DONE, data);
        host_read(CSR_SUM, data);
        check_value({name, " sum"}, expected, data);
    endtask

    // ==========================================================================
    // Directed tests
    // ==========================================================================

    task automatic test_csr_access();
        logic [31:0] value;
        logic [31:0] data;
        host_read(CSR_STATUS, data);
        check_value("status after reset", 32'h0, data);
        for (int i = 0; i < 4; i++)
        begin
            value = next_random();
            host_write(CSR_SCRATCH, value);
            host_read(CSR_SCRATCH, data);
            check_value("scratch readback", value, data);
        end
        host_read(ADDR_W'(4), data);
        check_value("unmapped csr 0x0004", 32'h0, data);
        host_read(ADDR_W'(16'h0040), data);
        check_value("unmapped csr 0x0040", 32'h0, data);
        host_read(ADDR_W'(16'h7fff), data);
        check_value("unmapped csr 0x7fff", 32'h0, data);
    endtask

    task automatic test_mem_window();
        logic [MEM_AW-1:0] addr;
        logic [31:0]       value;
        logic [31:0]       data;
        for (int i = 0; i < WIN_WORDS; i++)
        begin
            // Odd stride keeps the addresses distinct
            addr = MEM_AW'(i * 389 + 17);
            win_addrs[i] = addr;
            value = next_random();
            mem_model[addr] = value;
            host_write(window_addr(addr), value);
        end
        for (int i = WIN_WORDS - 1; i >= 0; i--)
        begin
            host_read(window_addr(win_addrs[i]), data);
            check_value("window readback", mem_model[win_addrs[i]], data);
        end
    endtask

    task automatic test_summing();
        logic [31:0] data;
        fill_range(MEM_AW'(100), 64);
        run_sum("sum of 64 words", MEM_AW'(100), 64);
        fill_range(MEM_AW'(MEM_WORDS - 6), 12);
        run_sum("sum across wrap", MEM_AW'(MEM_WORDS - 6), 12);
        host_command(MEM_AW'(200), 0);
        wait_sum_done(data);
        check_value("zero count status", STATUS_ERR_DONE, data);
    endtask

    task automatic test_back_pressure();
        logic [31:0] expected_q [$];
        logic [31:0] data;
        int          issued;
        int          idle;
        issued = 0;
        idle = 0;
        // Reads keep going in until the request side has stayed closed for a while
        while (idle < STALL_LIMIT && issued < ISSUE_LIMIT)
        begin
            if (host_req_ready)
            begin
                expected_q.push_back(mem_model[win_addrs[issued % WIN_WORDS]]);
                send_req(1'b0, window_addr(win_addrs[issued % WIN_WORDS]), 32'h0);
                issued++;
                idle = 0;
            end
            else
            begin
                @(negedge pClk);
                idle++;
            end
        end
        checks++;
        assert (!host_req_ready)
        else
        begin
            $display("Host request ready never dropped while responses were held back");
            errors++;
        end
        // The stall reaches back through the AFU into the request FIFO
        check_value("back-pressure accepted reads", 32'(BACKLOG_READS), 32'(issued));
        while (expected_q.size() > 0)
        begin
            recv_rsp(data);
            check_value("back-pressure read", expected_q.pop_front(), data);
        end
    endtask

    task automatic test_soft_reset();
        logic [31:0] data;
        int          cycles;
        host_write(CSR_SCRATCH, 32'ha5a5_5a5a);
        soft_reset_req = 1'b1;
        @(negedge pClk);
        soft_reset_req = 1'b0;
        cycles = 0;
        while (host_req_ready && cycles < WAIT_LIMIT)
        begin
            @(negedge pClk);
            cycles++;
        end
        if (host_req_ready)
            abort_run("Soft reset never took the host channel down");
        wait_link_up();
        host_read(CSR_SCRATCH, data);
        check_value("scratch after soft reset", 32'h0, data);
        host_read(CSR_STATUS, data);
        check_value("status after soft reset", 32'h0, data);
        // Memory contents survive the soft reset
        for (int i = 0; i < WIN_WORDS; i += 3)
        begin
            host_read(window_addr(win_addrs[i]), data);
            check_value("memory after soft reset", mem_model[win_addrs[i]], data);
        end
    endtask

    // ==========================================================================
    // Test sequence
    // ==========================================================================

    initial
    begin
        soft_reset_req = 1'b0;
        host_req = '0;
        host_req_valid = 1'b0;
        host_rsp_ready = 1'b0;
        rng_state = 32'h2352_1111;
        checks = 0;
        errors = 0;

        @(negedge pClk);
        wait_link_up();
        test_csr_access();
        test_mem_window();
        test_summing();
        test_back_pressure();
        test_soft_reset();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
#(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 3
)
(
    output logic pClk,
    output logic arst_n
);

    // Free-running platform clock, period of two half periods
    initial
    begin
        pClk = 1'b0;
        forever #HALF_PERIOD pClk = ~pClk;
    end

    // Reset covers the first rising edges and lifts between edges
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pClk);
        @(negedge pClk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/sim_platform_top.sv
`default_nettype none

module sim_platform_top
(
    input  logic                   pClk,
    input  logic                   arst_n,
    input  logic                   soft_reset_req,

    input  ofs_sim_pkg::host_req_t host_req,
    input  logic                   host_req_valid,
    output logic                   host_req_ready,

    output ofs_sim_pkg::host_rsp_t host_rsp,
    output logic                   host_rsp_valid,
    input  logic                   host_rsp_ready
);

    import ofs_sim_pkg::*;

    // Platform soft reset, shared by every block below
    logic soft_reset_n;

    // Host link toward the AFU
    host_req_t afu_req;
    logic      afu_req_valid;
    logic      afu_req_ready;
    host_rsp_t afu_rsp;
    logic      afu_rsp_valid;
    logic      afu_rsp_ready;

    // Local memory bank port
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_req_ready;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_valid;

    sim_reset_gen reset_gen
    (
        .pClk,
        .arst_n,
        .soft_reset_req,
        .soft_reset_n
    );

    host_chan_emul host_chan
    (
        .pClk,
        .arst_n,
        .soft_reset_n,
        .host_req,
        .host_req_valid,
        .host_req_ready,
        .host_rsp,
        .host_rsp_valid,
        .host_rsp_ready,
        .afu_req,
        .afu_req_valid,
        .afu_req_ready,
        .afu_rsp,
        .afu_rsp_valid,
        .afu_rsp_ready
    );

    local_mem_model local_mem
    (
        .pClk,
        .arst_n,
        .soft_reset_n,
        .mem_req,
        .mem_req_valid,
        .mem_req_ready,
        .mem_rsp,
        .mem_rsp_valid
    );

    afu_mem_sum afu
    (
        .pClk,
        .arst_n,
        .soft_reset_n,
        .afu_req,
        .afu_req_valid,
        .afu_req_ready,
        .afu_rsp,
        .afu_rsp_valid,
        .afu_rsp_ready,
        .mem_req,
        .mem_req_valid,
        .mem_req_ready,
        .mem_rsp,
        .mem_rsp_valid
    );

endmodule

`default_nettype wire

//--- verilog/afu_mem_sum.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

module afu_mem_sum
(
    input  logic                   pClk,
    input  logic                   arst_n,
    input  logic                   soft_reset_n,

    input  ofs_sim_pkg::host_req_t afu_req,
    input  logic                   afu_req_valid,
    output logic                   afu_req_ready,

    output ofs_sim_pkg::host_rsp_t afu_rsp,
    output logic                   afu_rsp_valid,
    input  logic                   afu_rsp_ready,

    output ofs_sim_pkg::mem_req_t  mem_req,
    output logic                   mem_req_valid,
    input  logic                   mem_req_ready,

    input  ofs_sim_pkg::mem_rsp_t  mem_rsp,
    input  logic                   mem_rsp_valid
);

    import ofs_sim_pkg::*;

    localparam int HAW = `OFS_HOST_ADDR_WIDTH;
    localparam int AW = `OFS_MEM_ADDR_WIDTH;
    localparam int DW = `OFS_DATA_WIDTH;
    localparam logic [HAW-2:0] CSR_SCRATCH = `OFS_CSR_SCRATCH;
    localparam logic [HAW-2:0] CSR_COMMAND = `OFS_CSR_COMMAND;
    localparam logic [HAW-2:0] CSR_SUM = `OFS_CSR_SUM;
    localparam logic [HAW-2:0] CSR_STATUS = `OFS_CSR_STATUS;

    // Request decode
    logic           is_win;
    logic [HAW-2:0] csr_addr;
    logic           is_cmd_wr;
    logic           req_ok;
    logic           accept;
    logic           csr_rd;
    logic           csr_wr;
    logic           win_rd;
    logic           win_rd_ret;
    sum_cmd_t       cmd;

    // CSR state
    logic [DW-1:0] scratch;
    logic [DW-1:0] sum;
    afu_status_t   status;
    logic [DW-1:0] csr_rdata;

    // Host response, at most one outstanding
    host_rsp_t rsp_q;
    logic      rsp_valid_q;
    logic      win_rd_wait;
    logic      rsp_pending;

    // Summing engine
    logic [AW-1:0] next_addr;
    logic [AW-1:0] issue_left;
    logic [AW-1:0] ret_left;
    logic          eng_issue;
    logic          eng_fire;

    // ==========================================================================
    // Host request decode and acceptance
    // ==========================================================================

    assign is_win = afu_req.addr[HAW-1];
    assign csr_addr = afu_req.addr[HAW-2:0];
    assign is_cmd_wr = !is_win && afu_req.is_write && (csr_addr == CSR_COMMAND);
    assign cmd = afu_req.data.cmd;
    assign rsp_pending = rsp_valid_q || win_rd_wait;

    // Window traffic and new commands wait for the engine
    // CSR reads always go through so that status can be polled
    always_comb
    begin
        if (is_win)
            req_ok = !status.busy && mem_req_ready;
        else if (is_cmd_wr)
            req_ok = !status.busy;
        else
            req_ok = 1'b1;
    end

    assign afu_req_ready = !rsp_pending && req_ok;
    assign accept = afu_req_valid && afu_req_ready;
    assign csr_rd = accept && !is_win && !afu_req.is_write;
    assign csr_wr = accept && !is_win && afu_req.is_write;
    assign win_rd = accept && is_win && !afu_req.is_write;
    assign win_rd_ret = win_rd_wait && mem_rsp_valid;

    // The command CSR is write-only and reads back as zero
    always_comb
    begin
        case (csr_addr)
            CSR_SCRATCH: csr_rdata = scratch;
            CSR_SUM:     csr_rdata = sum;
            CSR_STATUS:  csr_rdata = DW'(status);
            default:     csr_rdata = '0;
        endcase
    end

    // ==========================================================================
    // Memory port, owned by the engine while busy and by the window otherwise
    // ==========================================================================

    assign eng_issue = status.busy && (issue_left != '0);
    assign eng_fire = eng_issue && mem_req_ready;

    always_comb
    begin
        if (status.busy)
        begin
            mem_req_valid = eng_issue;
            mem_req.is_write = 1'b0;
            mem_req.addr = next_addr;
            mem_req.data = '0;
        end
        else
        begin
            mem_req_valid = afu_req_valid && is_win && !rsp_pending;
            mem_req.is_write = afu_req.is_write;
            mem_req.addr = afu_req.addr[AW-1:0];
            mem_req.data = afu_req.data.raw;
        end
    end

    assign afu_rsp = rsp_q;
    assign afu_rsp_valid = rsp_valid_q;

    // ==========================================================================
    // Control state
    // ==========================================================================

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_valid_q <= 1'b0;
            win_rd_wait <= 1'b0;
            scratch <= '0;
            sum <= '0;
            status <= '0;
            issue_left <= '0;
            ret_left <= '0;
        end
        else if (!soft_reset_n)
        begin
            rsp_valid_q <= 1'b0;
            win_rd_wait <= 1'b0;
            scratch <= '0;
            sum <= '0;
            status <= '0;
            issue_left <= '0;
            ret_left <= '0;
        end
        else
        begin
            // A new request is only taken with nothing pending, so these never collide
            if (afu_rsp_ready)
                rsp_valid_q <= 1'b0;
            if (csr_rd || win_rd_ret)
                rsp_valid_q <= 1'b1;
            if (win_rd)
                win_rd_wait <= 1'b1;
            else if (win_rd_ret)
                win_rd_wait <= 1'b0;

            if (csr_wr && csr_addr == CSR_SCRATCH)
                scratch <= afu_req.data.raw;

            if (accept && is_cmd_wr)
            begin
                // A zero count finishes at once and flags the error
                status.busy <= (cmd.count[AW-1:0] != '0);
                status.done <= (cmd.count[AW-1:0] == '0);
                status.cmd_error <= (cmd.count[AW-1:0] == '0);
                issue_left <= cmd.count[AW-1:0];
                ret_left <= cmd.count[AW-1:0];
                sum <= '0;
            end
            else if (status.busy)
            begin
                if (eng_fire)
                    issue_left <= issue_left - 1'b1;
                if (mem_rsp_valid)
                begin
                    // The sum wraps at 32 bits
                    sum <= sum + mem_rsp.data;
                    ret_left <= ret_left - 1'b1;
                    if (ret_left == AW'(1))
                    begin
                        status.busy <= 1'b0;
                        status.done <= 1'b1;
                    end
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge pClk)
    begin
        if (csr_rd)
            rsp_q.data <= csr_rdata;
        else if (win_rd_ret)
            rsp_q.data <= mem_rsp.data;

        // Consecutive addresses wrap at the end of the array
        if (accept && is_cmd_wr)
            next_addr <= cmd.base[AW-1:0];
        else if (eng_fire)
            next_addr <= next_addr + 1'b1;
    end

    // Memory never returns an engine read that was not issued
    assert property (@(posedge pClk) disable iff (!arst_n || !soft_reset_n)
        status.busy && mem_rsp_valid |-> ret_left > issue_left);

endmodule

`default_nettype wire

//--- verilog/local_mem_model.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

module local_mem_model
(
    input  logic                  pClk,
    input  logic                  arst_n,
    input  logic                  soft_reset_n,
    input  ofs_sim_pkg::mem_req_t mem_req,
    input  logic                  mem_req_valid,
    output logic                  mem_req_ready,
    output ofs_sim_pkg::mem_rsp_t mem_rsp,
    output logic                  mem_rsp_valid
);

    localparam int AW = `OFS_MEM_ADDR_WIDTH;
    localparam int DW = `OFS_DATA_WIDTH;
    localparam int LAT = `OFS_MEM_RD_LATENCY;

    // The array keeps its contents across a soft reset
    logic [DW-1:0] mem [2**AW];

    // Read pipeline whose stage 0 is loaded in the accept cycle
    logic [LAT-1:0] rd_valid;
    logic [DW-1:0]  rd_data [LAT];
    logic           rd_accept;
    logic           wr_accept;

    // The bank takes one request per cycle once out of reset
    assign mem_req_ready = soft_reset_n;
    assign rd_accept = mem_req_valid && mem_req_ready && !mem_req.is_write;
    assign wr_accept = mem_req_valid && mem_req_ready && mem_req.is_write;

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
            rd_valid <= '0;
        else if (!soft_reset_n)
            rd_valid <= '0;
        else
            rd_valid <= (rd_valid << 1) | LAT'(rd_accept);
    end

    // Data shifts alongside valid, so several reads can be in flight
    always_ff @(posedge pClk)
    begin
        if (wr_accept)
            mem[mem_req.addr] <= mem_req.data;
        rd_data[0] <= mem[mem_req.addr];
        for (int i = 1; i < LAT; i++)
            rd_data[i] <= rd_data[i-1];
    end

    // Exactly OFS_MEM_RD_LATENCY cycles from accept to response
    assign mem_rsp_valid = rd_valid[LAT-1];
    assign mem_rsp.data = rd_data[LAT-1];

    // The requester holds a waiting request steady until the bank takes it
    assert property (@(posedge pClk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

endmodule

`default_nettype wire

//--- verilog/host_chan_emul.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

module host_chan_emul
(
    input  logic                   pClk,
    input  logic                   arst_n,
    input  logic                   soft_reset_n,

    input  ofs_sim_pkg::host_req_t host_req,
    input  logic                   host_req_valid,
    output logic                   host_req_ready,

    output ofs_sim_pkg::host_rsp_t host_rsp,
    output logic                   host_rsp_valid,
    input  logic                   host_rsp_ready,

    output ofs_sim_pkg::host_req_t afu_req,
    output logic                   afu_req_valid,
    input  logic                   afu_req_ready,

    input  ofs_sim_pkg::host_rsp_t afu_rsp,
    input  logic                   afu_rsp_valid,
    output logic                   afu_rsp_ready
);

    import ofs_sim_pkg::*;

    localparam int DEPTH = `OFS_HOST_FIFO_DEPTH;
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL = CW'(DEPTH);

    // Request FIFO from host toward AFU
    host_req_t     req_mem [DEPTH];
    logic [PW-1:0] req_wr_ptr;
    logic [PW-1:0] req_rd_ptr;
    logic [CW-1:0] req_cnt;
    logic          req_push;
    logic          req_pop;

    // Response FIFO from AFU toward host
    host_rsp_t     rsp_mem [DEPTH];
    logic [PW-1:0] rsp_wr_ptr;
    logic [PW-1:0] rsp_rd_ptr;
    logic [CW-1:0] rsp_cnt;
    logic          rsp_push;
    logic          rsp_pop;

    // Link trained flag that keeps the host side closed through reset
    logic link_up;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign host_req_ready = link_up && (req_cnt != FULL);
    assign req_push = host_req_valid && host_req_ready;
    assign afu_req_valid = (req_cnt != '0);
    assign afu_req = req_mem[req_rd_ptr];
    assign req_pop = afu_req_valid && afu_req_ready;

    // A full response FIFO stalls the AFU, which in turn stops taking requests
    assign afu_rsp_ready = (rsp_cnt != FULL);
    assign rsp_push = afu_rsp_valid && afu_rsp_ready;
    assign host_rsp_valid = (rsp_cnt != '0);
    assign host_rsp = rsp_mem[rsp_rd_ptr];
    assign rsp_pop = host_rsp_valid && host_rsp_ready;

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            link_up <= 1'b0;
            req_wr_ptr <= '0;
            req_rd_ptr <= '0;
            req_cnt <= '0;
            rsp_wr_ptr <= '0;
            rsp_rd_ptr <= '0;
            rsp_cnt <= '0;
        end
        else if (!soft_reset_n)
        begin
            // Anything still in flight on the link is dropped
            link_up <= 1'b0;
            req_wr_ptr <= '0;
            req_rd_ptr <= '0;
            req_cnt <= '0;
            rsp_wr_ptr <= '0;
            rsp_rd_ptr <= '0;
            rsp_cnt <= '0;
        end
        else
        begin
            link_up <= 1'b1;
            if (req_push)
                req_wr_ptr <= next_ptr(req_wr_ptr);
            if (req_pop)
                req_rd_ptr <= next_ptr(req_rd_ptr);
            req_cnt <= req_cnt + CW'(req_push) - CW'(req_pop);
            if (rsp_push)
                rsp_wr_ptr <= next_ptr(rsp_wr_ptr);
            if (rsp_pop)
                rsp_rd_ptr <= next_ptr(rsp_rd_ptr);
            rsp_cnt <= rsp_cnt + CW'(rsp_push) - CW'(rsp_pop);
        end
    end

    // Entry storage
    always_ff @(posedge pClk)
    begin
        if (req_push)
            req_mem[req_wr_ptr] <= host_req;
        if (rsp_push)
            rsp_mem[rsp_wr_ptr] <= afu_rsp;
    end

    // Neither FIFO overflows or underflows and each count agrees with its pointers
    assert property (@(posedge pClk) disable iff (!arst_n)
        req_cnt <= FULL
        && ((req_wr_ptr == req_rd_ptr) == (req_cnt == '0 || req_cnt == FULL)));
    assert property (@(posedge pClk) disable iff (!arst_n)
        rsp_cnt <= FULL
        && ((rsp_wr_ptr == rsp_rd_ptr) == (rsp_cnt == '0 || rsp_cnt == FULL)));

endmodule

`default_nettype wire

//--- verilog/sim_reset_gen.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

module sim_reset_gen
(
    input  logic pClk,
    input  logic arst_n,
    input  logic soft_reset_req,
    output logic soft_reset_n
);

    localparam int HOLD = `OFS_RESET_HOLD_CYCLES;
    localparam int CW = $clog2(HOLD + 1);

    // Two-flop synchronizer for the request level from the host
    logic req_meta;
    logic req_sync;

    // Cycles left before the platform leaves reset
    logic [CW-1:0] hold_cnt;

    always_ff @(posedge pClk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            hold_cnt <= CW'(HOLD);
        end
        else
        begin
            req_meta <= soft_reset_req;
            req_sync <= req_meta;
            // Every request cycle restarts the full hold
            if (req_sync)
                hold_cnt <= CW'(HOLD);
            else if (hold_cnt != '0)
                hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Released only once the counter has drained
    assign soft_reset_n = (hold_cnt == '0);

    // A release is always preceded by the full hold of low cycles
    assert property (@(posedge pClk) disable iff (!arst_n)
        $rose(soft_reset_n) |-> $past(!soft_reset_n, HOLD));

endmodule

`default_nettype wire

//--- verilog/ofs_sim_pkg.sv
`default_nettype none

`include "ofs_sim_cfg.svh"

package ofs_sim_pkg;

    // Summing command as written to the command CSR
    // Only the low OFS_MEM_ADDR_WIDTH bits of each field reach the engine
    typedef struct packed {
        logic [15:0] base;
        logic [15:0] count;
    } sum_cmd_t;

    // One host data word
    // A command CSR write views it as sum_cmd_t, everything else as raw data
    typedef union packed {
        logic [`OFS_DATA_WIDTH-1:0] raw;
        sum_cmd_t                   cmd;
    } host_word_u;

    // Host request, used for both CSR and memory window accesses
    typedef struct packed {
        logic                           is_write;
        logic [`OFS_HOST_ADDR_WIDTH-1:0] addr;
        host_word_u                     data;
    } host_req_t;

    // Host read response
    typedef struct packed {
        logic [`OFS_DATA_WIDTH-1:0] data;
    } host_rsp_t;

    // Local memory request, writes are posted
    typedef struct packed {
        logic                          is_write;
        logic [`OFS_MEM_ADDR_WIDTH-1:0] addr;
        logic [`OFS_DATA_WIDTH-1:0]    data;
    } mem_req_t;

    // Local memory read response
    typedef struct packed {
        logic [`OFS_DATA_WIDTH-1:0] data;
    } mem_rsp_t;

    // Status CSR fields, busy in bit 0, done in bit 1, cmd_error in bit 2
    typedef struct packed {
        logic cmd_error;
        logic done;
        logic busy;
    } afu_status_t;

endpackage

`default_nettype wire

//--- verilog/ofs_sim_cfg.svh
`ifndef OFS_SIM_CFG_SVH
`define OFS_SIM_CFG_SVH

// Host channel word address and data widths
// The top address bit selects the local memory window
`define OFS_HOST_ADDR_WIDTH 16
`define OFS_DATA_WIDTH 32

// One local memory bank, word addressed, with a fixed read latency
`define OFS_MEM_ADDR_WIDTH 10
`define OFS_MEM_RD_LATENCY 2

// Buffering in each direction of the emulated host link
`define OFS_HOST_FIFO_DEPTH 4

// Cycles that the platform soft reset stays asserted
`define OFS_RESET_HOLD_CYCLES 8

// AFU CSR word addresses below the memory window
`define OFS_CSR_SCRATCH 0
`define OFS_CSR_COMMAND 1
`define OFS_CSR_SUM 2
`define OFS_CSR_STATUS 3

`endif
